//--- flist.f
rtl/cdb_pkg.sv
rtl/result_buffer.sv
rtl/cdb_arbitrator.sv
rtl/rob_completion.sv
rtl/cdb_subsystem.sv
tests/cdb_subsystem_chk.sv
tests/cdb_subsystem_tb.sv

//--- rtl/cdb_arbitrator.sv
`timescale 1ns/100ps

module cdb_arbitrator import cdb_pkg::*; #(
	parameter int alu_lanes    = 4,
	parameter int branch_lanes = 2,
	parameter int lsu_lanes    = 2
) (
	input  logic           [alu_lanes-1:0]    alu_ready,
	input  alu_result_t    [alu_lanes-1:0]    alu_payload,
	output logic           [alu_lanes-1:0]    alu_ack,

	input  logic           [branch_lanes-1:0] branch_ready,
	input  branch_result_t [branch_lanes-1:0] branch_payload,
	output logic           [branch_lanes-1:0] branch_ack,

	input  logic           [lsu_lanes-1:0]    lsu_ready,
	input  lsu_result_t    [lsu_lanes-1:0]    lsu_payload,
	output logic           [lsu_lanes-1:0]    lsu_ack,

	input  logic                              cp0_ready,
	input  cp0_result_t                       cp0_payload,
	output logic                              cp0_ack,

	output cdb_lane_t      [alu_lanes-1:0]    cdb
);

	localparam int cp0_lane = branch_lanes + 1; // Shares this lane with the ALU only.

	always_comb begin
		cdb        = '0;
		alu_ack    = '0;
		branch_ack = '0;
		lsu_ack    = '0;
		cp0_ack    = 1'b0;

		// Lowest priority first, each later stage overwrites the lane it wins.
		for (int i = 0; i < alu_lanes; i++) begin
			alu_ack[i]     = alu_ready[i];
			cdb[i].valid   = alu_ready[i];
			cdb[i].src     = src_alu;
			cdb[i].reorder = alu_payload[i].reorder;
			cdb[i].value   = alu_payload[i].value;
			cdb[i].ex      = alu_payload[i].ex;
		end

		for (int i = 0; i < branch_lanes; i++) begin
			if (branch_ready[i]) begin
				alu_ack[i]                 = 1'b0;
				branch_ack[i]              = 1'b1;
				cdb[i]                     = '0;
				cdb[i].valid               = 1'b1;
				cdb[i].src                 = src_branch;
				cdb[i].reorder             = branch_payload[i].reorder;
				cdb[i].value               = branch_payload[i].value;
				cdb[i].aux.resolved_branch = branch_payload[i].resolved;
			end
		end

		if (cp0_ready) begin
			alu_ack[cp0_lane]     = 1'b0;
			cp0_ack               = 1'b1;
			cdb[cp0_lane]         = '0;
			cdb[cp0_lane].valid   = 1'b1;
			cdb[cp0_lane].src     = src_cp0;
			cdb[cp0_lane].reorder = cp0_payload.reorder;
			cdb[cp0_lane].value   = cp0_payload.value;
			cdb[cp0_lane].ex      = cp0_payload.ex;
		end

		for (int i = 0; i < lsu_lanes; i++) begin
			if (lsu_ready[i]) begin
				alu_ack[i] = 1'b0;
				if (i < branch_lanes) begin
					branch_ack[i] = 1'b0;
				end
				if (i == cp0_lane) begin
					cp0_ack = 1'b0;
				end
				lsu_ack[i]        = 1'b1;
				cdb[i]            = '0;
				cdb[i].valid      = 1'b1;
				cdb[i].src        = src_lsu;
				cdb[i].reorder    = lsu_payload[i].reorder;
				cdb[i].value      = lsu_payload[i].value;
				cdb[i].ex         = lsu_payload[i].ex;
				cdb[i].aux.memreq = lsu_payload[i].memreq;
			end
		end
	end

endmodule

//--- rtl/cdb_pkg.sv
package cdb_pkg;

	localparam int rob_index_w = 4; // Tag width, which limits the reorder buffer to 16 entries.

	typedef logic [31:0] uint32_t;

	typedef logic [rob_index_w-1:0] rob_index_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] cause;
	} exception_t;

	typedef struct packed {
		logic        taken;
		logic        mispredict;
		logic [29:0] target; // Word address of the resolved target.
	} branch_resolved_t;

	typedef struct packed {
		logic        write;
		logic [1:0]  size;
		logic [28:0] addr; // Word address, no spare bits left.
	} data_memreq_t;

	// The src field of the lane says which of the two views holds.
	typedef union packed {
		branch_resolved_t resolved_branch;
		data_memreq_t     memreq;
	} cdb_aux_t;

	typedef enum logic [1:0] {
		src_alu    = 2'd0,
		src_branch = 2'd1,
		src_lsu    = 2'd2,
		src_cp0    = 2'd3
	} cdb_src_t;

	typedef struct packed {
		logic       valid;
		cdb_src_t   src;
		rob_index_t reorder;
		uint32_t    value;
		exception_t ex;
		cdb_aux_t   aux;
	} cdb_lane_t;

	typedef struct packed {
		rob_index_t reorder;
		uint32_t    value;
		exception_t ex;
	} alu_result_t;

	typedef struct packed {
		rob_index_t       reorder;
		uint32_t          value; // Link value for jump-and-link.
		branch_resolved_t resolved;
	} branch_result_t;

	typedef struct packed {
		rob_index_t   reorder;
		uint32_t      value;
		exception_t   ex;
		data_memreq_t memreq;
	} lsu_result_t;

	typedef struct packed {
		rob_index_t reorder;
		uint32_t    value;
		exception_t ex;
	} cp0_result_t;

endpackage

//--- rtl/cdb_subsystem.sv
`timescale 1ns/100ps

module cdb_subsystem import cdb_pkg::*; #(
	parameter int alu_lanes    = 4,
	parameter int branch_lanes = 2,
	parameter int lsu_lanes    = 2,
	parameter int rob_depth    = 16
) (
	input  logic                              clk,
	input  logic                              rst,

	input  logic           [alu_lanes-1:0]    alu_valid,
	input  alu_result_t    [alu_lanes-1:0]    alu_in,
	output logic           [alu_lanes-1:0]    alu_free,

	input  logic           [branch_lanes-1:0] branch_valid,
	input  branch_result_t [branch_lanes-1:0] branch_in,
	output logic           [branch_lanes-1:0] branch_free,

	input  logic           [lsu_lanes-1:0]    lsu_valid,
	input  lsu_result_t    [lsu_lanes-1:0]    lsu_in,
	output logic           [lsu_lanes-1:0]    lsu_free,

	input  logic                              cp0_valid,
	input  cp0_result_t                       cp0_in,
	output logic                              cp0_free,

	input  logic                              alloc_valid,
	output logic                              alloc_ready,
	output rob_index_t                        alloc_index,

	output logic                              retire_valid,
	input  logic                              retire_ack,
	output rob_index_t                        retire_index,
	output uint32_t                           retire_value,
	output exception_t                        retire_ex,
	output cdb_aux_t                          retire_aux
);

	logic           [alu_lanes-1:0]    alu_ready;
	logic           [alu_lanes-1:0]    alu_ack;
	alu_result_t    [alu_lanes-1:0]    alu_held;
	logic           [branch_lanes-1:0] branch_ready;
	logic           [branch_lanes-1:0] branch_ack;
	branch_result_t [branch_lanes-1:0] branch_held;
	logic           [lsu_lanes-1:0]    lsu_ready;
	logic           [lsu_lanes-1:0]    lsu_ack;
	lsu_result_t    [lsu_lanes-1:0]    lsu_held;
	logic                              cp0_ready;
	logic                              cp0_ack;
	cp0_result_t                       cp0_held;
	cdb_lane_t      [alu_lanes-1:0]    cdb;

	for (genvar i = 0; i < alu_lanes; i++) begin : g_alu_buf
		result_buffer #(.payload_w($bits(alu_result_t))) alu_buf_inst (
			.clk(clk), .rst(rst),
			.in_valid(alu_valid[i]), .in_payload(alu_in[i]), .free(alu_free[i]),
			.ready(alu_ready[i]), .payload(alu_held[i]), .ack(alu_ack[i])
		);
	end

	for (genvar i = 0; i < branch_lanes; i++) begin : g_branch_buf
		result_buffer #(.payload_w($bits(branch_result_t))) branch_buf_inst (
			.clk(clk), .rst(rst),
			.in_valid(branch_valid[i]), .in_payload(branch_in[i]), .free(branch_free[i]),
			.ready(branch_ready[i]), .payload(branch_held[i]), .ack(branch_ack[i])
		);
	end

	for (genvar i = 0; i < lsu_lanes; i++) begin : g_lsu_buf
		result_buffer #(.payload_w($bits(lsu_result_t))) lsu_buf_inst (
			.clk(clk), .rst(rst),
			.in_valid(lsu_valid[i]), .in_payload(lsu_in[i]), .free(lsu_free[i]),
			.ready(lsu_ready[i]), .payload(lsu_held[i]), .ack(lsu_ack[i])
		);
	end

	result_buffer #(.payload_w($bits(cp0_result_t))) cp0_buf_inst (
		.clk(clk), .rst(rst),
		.in_valid(cp0_valid), .in_payload(cp0_in), .free(cp0_free),
		.ready(cp0_ready), .payload(cp0_held), .ack(cp0_ack)
	);

	cdb_arbitrator #(
		.alu_lanes(alu_lanes), .branch_lanes(branch_lanes), .lsu_lanes(lsu_lanes)
	) cdb_arbitrator_inst (
		.alu_ready(alu_ready), .alu_payload(alu_held), .alu_ack(alu_ack),
		.branch_ready(branch_ready), .branch_payload(branch_held), .branch_ack(branch_ack),
		.lsu_ready(lsu_ready), .lsu_payload(lsu_held), .lsu_ack(lsu_ack),
		.cp0_ready(cp0_ready), .cp0_payload(cp0_held), .cp0_ack(cp0_ack),
		.cdb(cdb)
	);

	rob_completion #(.alu_lanes(alu_lanes), .rob_depth(rob_depth)) rob_completion_inst (
		.clk(clk), .rst(rst),
		.alloc_valid(alloc_valid), .alloc_ready(alloc_ready), .alloc_index(alloc_index),
		.cdb(cdb),
		.retire_valid(retire_valid), .retire_ack(retire_ack),
		.retire_index(retire_index), .retire_value(retire_value),
		.retire_ex(retire_ex), .retire_aux(retire_aux)
	);

endmodule

//--- rtl/result_buffer.sv
`timescale 1ns/100ps

module result_buffer #(
	parameter int payload_w = 32
) (
	input  logic                 clk,
	input  logic                 rst,

	input  logic                 in_valid,
	input  logic [payload_w-1:0] in_payload,
	output logic                 free,

	output logic                 ready,
	output logic [payload_w-1:0] payload,
	input  logic                 ack
);

	logic                 full;
	logic [payload_w-1:0] held;
	logic                 load;

	assign load = in_valid && !full; // Take a result only into an empty slot.

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (ack) begin
			full <= 1'b0; // Drained onto the bus this cycle.
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			held <= in_payload;
		end
	end

	// While the arbitrator holds us off, free stays low and stalls the producer.
	assign free    = !full;
	assign ready   = full;
	assign payload = held;

endmodule

//--- rtl/rob_completion.sv
`timescale 1ns/100ps

module rob_completion import cdb_pkg::*; #(
	parameter int alu_lanes = 4,
	parameter int rob_depth = 16
) (
	input  logic                       clk,
	input  logic                       rst,

	input  logic                       alloc_valid,
	output logic                       alloc_ready,
	output rob_index_t                 alloc_index,

	input  cdb_lane_t  [alu_lanes-1:0] cdb,

	output logic                       retire_valid,
	input  logic                       retire_ack,
	output rob_index_t                 retire_index,
	output uint32_t                    retire_value,
	output exception_t                 retire_ex,
	output cdb_aux_t                   retire_aux
);

	localparam int count_w = $clog2(rob_depth + 1);

	rob_index_t         head;
	rob_index_t         tail;
	logic [count_w-1:0] count;

	logic [rob_depth-1:0] done;
	uint32_t              value [rob_depth];
	exception_t           ex    [rob_depth];
	cdb_aux_t             aux   [rob_depth];

	logic alloc_fire;
	logic retire_fire;

	function automatic rob_index_t wrap_inc(input rob_index_t ptr);
		rob_index_t next;
		if (ptr == rob_index_t'(rob_depth - 1)) begin
			next = '0;
		end else begin
			next = ptr + 1'b1;
		end
		return next;
	endfunction

	assign alloc_ready = (count != count_w'(rob_depth));
	assign alloc_index = tail;
	assign alloc_fire  = alloc_valid && alloc_ready;

	// The head may only leave once its result has been broadcast.
	assign retire_valid = (count != '0) && done[head];
	assign retire_fire  = retire_valid && retire_ack;
	assign retire_index = head;
	assign retire_value = value[head];
	assign retire_ex    = ex[head];
	assign retire_aux   = aux[head];

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (alloc_fire) begin
				tail <= wrap_inc(tail);
			end
			if (retire_fire) begin
				head <= wrap_inc(head);
			end
			if (alloc_fire && !retire_fire) begin
				count <= count + 1'b1;
			end else if (retire_fire && !alloc_fire) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= '0;
		end else begin
			if (retire_fire) begin
				done[head] <= 1'b0; // Frees the slot for the next allocation.
			end
			for (int i = 0; i < alu_lanes; i++) begin
				if (cdb[i].valid) begin
					done[cdb[i].reorder] <= 1'b1;
				end
			end
		end
	end

	// Lanes carry distinct tags, so no two lanes write the same entry.
	always_ff @(posedge clk) begin
		for (int i = 0; i < alu_lanes; i++) begin
			if (cdb[i].valid) begin
				value[cdb[i].reorder] <= cdb[i].value;
				ex[cdb[i].reorder]    <= cdb[i].ex;
				aux[cdb[i].reorder]   <= cdb[i].aux;
			end
		end
	end

endmodule

//--- tests/cdb_subsystem_chk.sv
`timescale 1ns/100ps

module cdb_subsystem_chk #(
	parameter int alu_lanes    = 4,
	parameter int branch_lanes = 2,
	parameter int lsu_lanes    = 2,
	parameter int rob_depth    = 16
) (
	input logic                             clk,
	input logic                             rst,
	input logic [alu_lanes-1:0]             alu_ready,
	input logic [alu_lanes-1:0]             alu_ack,
	input logic [branch_lanes-1:0]          branch_ready,
	input logic [branch_lanes-1:0]          branch_ack,
	input logic [lsu_lanes-1:0]             lsu_ready,
	input logic [lsu_lanes-1:0]             lsu_ack,
	input logic                             cp0_ready,
	input logic                             cp0_ack,
	input logic                             alloc_valid,
	input logic                             alloc_ready,
	input logic                             retire_valid,
	input logic                             retire_ack
);

	localparam int cp0_lane = branch_lanes + 1;
	localparam int occ_w    = $clog2(rob_depth + 1);

	logic [2:0]           grants [alu_lanes];
	logic [alu_lanes-1:0] shared_lane;
	logic [occ_w-1:0]     occupancy; // Allocated entries that have not retired yet.

	always_comb begin
		for (int i = 0; i < alu_lanes; i++) begin
			grants[i] = 3'(alu_ack[i]);
		end
		for (int i = 0; i < branch_lanes; i++) begin
			grants[i] = grants[i] + 3'(branch_ack[i]);
		end
		for (int i = 0; i < lsu_lanes; i++) begin
			grants[i] = grants[i] + 3'(lsu_ack[i]);
		end
		grants[cp0_lane] = grants[cp0_lane] + 3'(cp0_ack);
		for (int i = 0; i < alu_lanes; i++) begin
			shared_lane[i] = (grants[i] > 3'd1); // Two winners would drop a result.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			occupancy <= '0;
		end else begin
			occupancy <= occupancy + occ_w'(alloc_valid && alloc_ready)
				- occ_w'(retire_valid && retire_ack);
		end
	end

	assert property (@(posedge clk) disable iff (rst) shared_lane == '0)
		else $error("More than one producer was acknowledged on one cdb lane.");

	assert property (@(posedge clk) disable iff (rst)
		(alu_ack & ~alu_ready) == '0 && (branch_ack & ~branch_ready) == '0 &&
		(lsu_ack & ~lsu_ready) == '0 && !(cp0_ack && !cp0_ready))
		else $error("A producer was acknowledged while its buffer was not ready.");

	assert property (@(posedge clk) disable iff (rst) occupancy == rob_depth |-> !alloc_ready)
		else $error("alloc_ready stayed high with a full reorder buffer.");

	assert property (@(posedge clk) rst |-> !$rose(retire_valid))
		else $error("retire_valid rose while reset was held.");

endmodule

//--- tests/cdb_subsystem_tb.sv
`timescale 1ns/100ps

module cdb_subsystem_tb import cdb_pkg::*; ();

	localparam int alu_lanes    = 4;
	localparam int branch_lanes = 2;
	localparam int lsu_lanes    = 2;
	localparam int rob_depth    = 16;
	localparam int cp0_lane     = branch_lanes + 1;
	localparam int timeout      = 1000; // Clock cycles per wait.

	typedef struct packed {
		rob_index_t tag;
		cdb_src_t   unit;
	} pending_t;

	logic                              clk;
	logic                              rst;
	logic           [alu_lanes-1:0]    alu_valid;
	alu_result_t    [alu_lanes-1:0]    alu_in;
	logic           [alu_lanes-1:0]    alu_free;
	logic           [branch_lanes-1:0] branch_valid;
	branch_result_t [branch_lanes-1:0] branch_in;
	logic           [branch_lanes-1:0] branch_free;
	logic           [lsu_lanes-1:0]    lsu_valid;
	lsu_result_t    [lsu_lanes-1:0]    lsu_in;
	logic           [lsu_lanes-1:0]    lsu_free;
	logic                              cp0_valid;
	cp0_result_t                       cp0_in;
	logic                              cp0_free;
	logic                              alloc_valid;
	logic                              alloc_ready;
	rob_index_t                        alloc_index;
	logic                              retire_valid;
	logic                              retire_ack;
	rob_index_t                        retire_index;
	uint32_t                           retire_value;
	exception_t                        retire_ex;
	cdb_aux_t                          retire_aux;

	logic       hold_retire; // Keeps the comparing process from acking.
	rob_index_t next_tag; // The ring hands out tags in order and wraps at the depth.
	pending_t   expected_q [$];

	cdb_subsystem cdb_subsystem_inst (.*);

	bind cdb_subsystem cdb_subsystem_chk #(
		.alu_lanes(alu_lanes), .branch_lanes(branch_lanes),
		.lsu_lanes(lsu_lanes), .rob_depth(rob_depth)
	) cdb_subsystem_chk_inst (
		.clk(clk), .rst(rst),
		.alu_ready(alu_ready), .alu_ack(alu_ack),
		.branch_ready(branch_ready), .branch_ack(branch_ack),
		.lsu_ready(lsu_ready), .lsu_ack(lsu_ack),
		.cp0_ready(cp0_ready), .cp0_ack(cp0_ack),
		.alloc_valid(alloc_valid), .alloc_ready(alloc_ready),
		.retire_valid(retire_valid), .retire_ack(retire_ack)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic void reference_result(input rob_index_t tag, input cdb_src_t unit,
			output uint32_t value, output exception_t ex, output cdb_aux_t aux);
		value = (32'h9e37_79b9 * (32'(tag) + 32'd1)) ^ (32'(unit) << 28);
		ex    = '0;
		aux   = '0;
		if (unit != src_branch && tag % 7 == 6) begin
			ex.valid = 1'b1; // Branch results carry no exception field.
			ex.cause = 5'(tag) + 5'(unit);
		end
		if (unit == src_branch) begin
			aux.resolved_branch.taken      = tag[0];
			aux.resolved_branch.mispredict = tag[1];
			aux.resolved_branch.target     = value[31:2];
		end else if (unit == src_lsu) begin
			aux.memreq.write = tag[0];
			aux.memreq.size  = tag[2:1];
			aux.memreq.addr  = value[31:3];
		end
	endfunction

	task automatic end_in_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end_in_failure();
	endtask

	task automatic report_failure(input string what);
		$display("At %0t ns: %s", $time, what);
		end_in_failure();
	endtask

	function automatic logic unit_free(input cdb_src_t unit, input int lane);
		case (unit)
			src_alu:    return alu_free[lane];
			src_branch: return branch_free[lane];
			src_lsu:    return lsu_free[lane];
			default:    return cp0_free;
		endcase
	endfunction

	function automatic int random_lane(input cdb_src_t unit);
		case (unit)
			src_alu:    return $urandom_range(alu_lanes - 1);
			src_branch: return $urandom_range(branch_lanes - 1);
			src_lsu:    return $urandom_range(lsu_lanes - 1);
			default:    return 0;
		endcase
	endfunction

	task automatic wait_free(input cdb_src_t unit, input int lane);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!unit_free(unit, lane)) begin
			cycles++;
			if (cycles > timeout) begin
				report_failure("A result buffer never became free.");
			end
			@(negedge clk);
		end
	endtask

	task automatic allocate(input cdb_src_t unit, output rob_index_t tag);
		pending_t entry;
		int       cycles;
		cycles = 0;
		@(negedge clk);
		while (!alloc_ready) begin
			cycles++;
			if (cycles > timeout) begin
				report_failure("alloc_ready never came back high.");
			end
			@(negedge clk);
		end
		tag = next_tag;
		assert (alloc_index == tag) else report_mismatch("alloc_index", tag, alloc_index);
		next_tag = rob_index_t'((next_tag + 1) % rob_depth);
		@(posedge clk);
		alloc_valid <= 1'b1;
		@(posedge clk);
		alloc_valid <= 1'b0;
		entry.tag  = tag;
		entry.unit = unit;
		expected_q.push_back(entry);
	endtask

	task automatic drive_result(input cdb_src_t unit, input int lane, input rob_index_t tag);
		uint32_t    value;
		exception_t ex;
		cdb_aux_t   aux;
		reference_result(tag, unit, value, ex, aux);
		case (unit)
			src_alu: begin
				alu_in[lane]    <= '{tag, value, ex};
				alu_valid[lane] <= 1'b1;
			end
			src_branch: begin
				branch_in[lane]    <= '{tag, value, aux.resolved_branch};
				branch_valid[lane] <= 1'b1;
			end
			src_lsu: begin
				lsu_in[lane]    <= '{tag, value, ex, aux.memreq};
				lsu_valid[lane] <= 1'b1;
			end
			default: begin
				cp0_in    <= '{tag, value, ex};
				cp0_valid <= 1'b1;
			end
		endcase
	endtask

	task automatic clear_valids();
		alu_valid    <= '0;
		branch_valid <= '0;
		lsu_valid    <= '0;
		cp0_valid    <= 1'b0;
	endtask

	task automatic send_result(input cdb_src_t unit, input int lane, input rob_index_t tag);
		wait_free(unit, lane);
		@(posedge clk);
		drive_result(unit, lane, tag);
		@(posedge clk);
		clear_valids();
	endtask

	task automatic run_batch(input int size);
		pending_t batch [$];
		pending_t entry;
		int       pick;
		for (int i = 0; i < size; i++) begin
			entry.unit = cdb_src_t'($urandom_range(3));
			allocate(entry.unit, entry.tag);
			batch.push_back(entry);
		end
		while (batch.size() != 0) begin
			pick  = $urandom_range(batch.size() - 1); // Completion order differs from allocation.
			entry = batch[pick];
			batch.delete(pick);
			send_result(entry.unit, random_lane(entry.unit), entry.tag);
		end
	endtask

	// ALU, branch and LSU all land on one lane in the same cycle.
	task automatic collide_lane(input int lane);
		rob_index_t alu_tag;
		rob_index_t branch_tag;
		rob_index_t lsu_tag;
		allocate(src_alu, alu_tag);
		allocate(src_branch, branch_tag);
		allocate(src_lsu, lsu_tag);
		wait_free(src_alu, lane);
		wait_free(src_branch, lane);
		wait_free(src_lsu, lane);
		@(posedge clk);
		drive_result(src_alu, lane, alu_tag);
		drive_result(src_branch, lane, branch_tag);
		drive_result(src_lsu, lane, lsu_tag);
		@(posedge clk);
		clear_valids();
	endtask

	task automatic collide_cp0();
		rob_index_t alu_tag;
		rob_index_t cp0_tag;
		allocate(src_cp0, cp0_tag);
		allocate(src_alu, alu_tag);
		wait_free(src_alu, cp0_lane);
		wait_free(src_cp0, 0);
		@(posedge clk);
		drive_result(src_alu, cp0_lane, alu_tag);
		drive_result(src_cp0, 0, cp0_tag);
		@(posedge clk);
		clear_valids();
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (expected_q.size() != 0 || retire_valid) begin
			cycles++;
			if (cycles > timeout) begin
				report_failure("The reorder buffer did not drain.");
			end
			@(negedge clk);
		end
	endtask

	task automatic fill_rob();
		pending_t held [$];
		pending_t entry;
		wait_drained();
		@(posedge clk);
		hold_retire <= 1'b1;
		for (int i = 0; i < rob_depth; i++) begin
			entry.unit = cdb_src_t'($urandom_range(3));
			allocate(entry.unit, entry.tag);
			held.push_back(entry);
		end
		@(negedge clk);
		assert (alloc_ready == 1'b0) else report_mismatch("alloc_ready", 64'd0, alloc_ready);
		foreach (held[i]) begin
			send_result(held[i].unit, random_lane(held[i].unit), held[i].tag);
		end
		@(negedge clk);
		assert (alloc_ready == 1'b0) else report_mismatch("alloc_ready", 64'd0, alloc_ready);
		@(posedge clk);
		hold_retire <= 1'b0;
	endtask

	task automatic wait_retire();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rst || !retire_valid || hold_retire) begin
			if (!rst && !hold_retire && expected_q.size() != 0) begin
				cycles++; // Only outstanding work counts toward the timeout.
			end
			if (cycles > timeout) begin
				report_failure("retire_valid never rose for an outstanding entry.");
			end
			@(negedge clk);
		end
	endtask

	initial begin : compare_retirements
		pending_t   entry;
		uint32_t    value;
		exception_t ex;
		cdb_aux_t   aux;
		forever begin
			wait_retire();
			assert (expected_q.size() != 0)
				else report_failure("An entry retired that was never allocated.");
			entry = expected_q.pop_front();
			reference_result(entry.tag, entry.unit, value, ex, aux);
			assert (retire_index == entry.tag)
				else report_mismatch("retire_index", entry.tag, retire_index);
			assert (retire_value == value) else report_mismatch("retire_value", value, retire_value);
			assert (retire_ex == ex) else report_mismatch("retire_ex", ex, retire_ex);
			if (entry.unit == src_branch) begin
				assert (retire_aux.resolved_branch == aux.resolved_branch)
					else report_mismatch("retire_aux.resolved_branch", aux, retire_aux);
			end else if (entry.unit == src_lsu) begin
				assert (retire_aux.memreq == aux.memreq)
					else report_mismatch("retire_aux.memreq", aux, retire_aux);
			end else begin
				assert (retire_aux == aux) else report_mismatch("retire_aux", aux, retire_aux);
			end
			@(posedge clk);
			retire_ack <= 1'b1;
			@(posedge clk);
			retire_ack <= 1'b0;
		end
	end

	initial begin : stimulus
		void'($urandom(93503));
		rst          = 1'b1;
		alu_valid    = '0;
		alu_in       = '0;
		branch_valid = '0;
		branch_in    = '0;
		lsu_valid    = '0;
		lsu_in       = '0;
		cp0_valid    = 1'b0;
		cp0_in       = '0;
		alloc_valid  = 1'b0;
		retire_ack   = 1'b0;
		hold_retire  = 1'b0;
		next_tag     = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (retire_valid == 1'b0) else report_mismatch("retire_valid", 64'd0, retire_valid);
		assert (alloc_ready == 1'b1) else report_mismatch("alloc_ready", 64'd1, alloc_ready);
		assert (alu_free == '1) else report_mismatch("alu_free", {alu_lanes{1'b1}}, alu_free);
		assert (branch_free == '1)
			else report_mismatch("branch_free", {branch_lanes{1'b1}}, branch_free);
		assert (lsu_free == '1) else report_mismatch("lsu_free", {lsu_lanes{1'b1}}, lsu_free);
		assert (cp0_free == 1'b1) else report_mismatch("cp0_free", 64'd1, cp0_free);
		repeat (6) run_batch(4);
		collide_lane(0);
		collide_lane(1);
		collide_cp0();
		fill_rob();
		run_batch(4); // Allocation resumes once the held entries retire.
		wait_drained();
		$display("TEST PASSED");
		$finish;
	end

endmodule
